/* project.f */
rtl/axi_fields_pkg.sv
rtl/dc_ring_pkg.sv
rtl/dc_ring_reader.sv
rtl/dc_ring_writer.sv
rtl/channel_buffer.sv
rtl/axi_slice_dc_master.sv
verification/tb_axi_slice_dc_master.sv

/* rtl/axi_fields_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// AXI4 write-path field widths and channel word layouts, fields from bit 0 up.
// Region, qos and user are not carried, and the read channels are not defined.
// ~~~~~~~~~~~~~~~~~~~~
package axi_fields_pkg;

    localparam int unsigned ADDR_WIDTH  = 32;
    localparam int unsigned DATA_WIDTH  = 32;
    localparam int unsigned STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int unsigned ID_WIDTH    = 4;
    localparam int unsigned LEN_WIDTH   = 8;
    localparam int unsigned SIZE_WIDTH  = 3;
    localparam int unsigned BURST_WIDTH = 2;
    localparam int unsigned CACHE_WIDTH = 4;
    localparam int unsigned PROT_WIDTH  = 3;
    localparam int unsigned RESP_WIDTH  = 2;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [STRB_WIDTH-1:0]  strb_t;
    typedef logic [ID_WIDTH-1:0]    id_t;
    typedef logic [LEN_WIDTH-1:0]   len_t;
    typedef logic [SIZE_WIDTH-1:0]  size_t;
    typedef logic [BURST_WIDTH-1:0] burst_t;
    typedef logic [CACHE_WIDTH-1:0] cache_t;
    typedef logic [PROT_WIDTH-1:0]  prot_t;
    typedef logic [RESP_WIDTH-1:0]  resp_t;

    // Write address word
    localparam int unsigned AW_CACHE_LSB  = 0;
    localparam int unsigned AW_PROT_LSB   = AW_CACHE_LSB + CACHE_WIDTH;
    localparam int unsigned AW_LOCK_LSB   = AW_PROT_LSB + PROT_WIDTH;
    localparam int unsigned AW_BURST_LSB  = AW_LOCK_LSB + 1;
    localparam int unsigned AW_SIZE_LSB   = AW_BURST_LSB + BURST_WIDTH;
    localparam int unsigned AW_LEN_LSB    = AW_SIZE_LSB + SIZE_WIDTH;
    localparam int unsigned AW_ADDR_LSB   = AW_LEN_LSB + LEN_WIDTH;
    localparam int unsigned AW_ID_LSB     = AW_ADDR_LSB + ADDR_WIDTH;
    localparam int unsigned AW_WORD_WIDTH = AW_ID_LSB + ID_WIDTH;

    // Write data word
    localparam int unsigned W_LAST_LSB   = 0;
    localparam int unsigned W_DATA_LSB   = W_LAST_LSB + 1;
    localparam int unsigned W_STRB_LSB   = W_DATA_LSB + DATA_WIDTH;
    localparam int unsigned W_WORD_WIDTH = W_STRB_LSB + STRB_WIDTH;

    // Write response word
    localparam int unsigned B_RESP_LSB   = 0;
    localparam int unsigned B_ID_LSB     = B_RESP_LSB + RESP_WIDTH;
    localparam int unsigned B_WORD_WIDTH = B_ID_LSB + ID_WIDTH;

    typedef logic [AW_WORD_WIDTH-1:0] aw_word_t;
    typedef logic [W_WORD_WIDTH-1:0]  w_word_t;
    typedef logic [B_WORD_WIDTH-1:0]  b_word_t;

endpackage

/* rtl/axi_slice_dc_master.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Master half of a dual-clock AXI4 slice, write path only (AW, W, B).
// The remote half owns the AW and W ring storage; B storage is local.
// All ring pointers are Gray coded with one wrap bit.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axi_slice_dc_master (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Remote half, write address
    input  dc_ring_pkg::ring_ptr_t       aw_wr_ptr_i,
    output dc_ring_pkg::ring_ptr_t       aw_rd_ptr_o,
    input  axi_fields_pkg::aw_word_t     aw_word_async_i,

    // Remote half, write data
    input  dc_ring_pkg::ring_ptr_t       w_wr_ptr_i,
    output dc_ring_pkg::ring_ptr_t       w_rd_ptr_o,
    input  axi_fields_pkg::w_word_t      w_word_async_i,

    // Remote half, write response
    output dc_ring_pkg::ring_ptr_t       b_wr_ptr_o,
    input  dc_ring_pkg::ring_ptr_t       b_rd_ptr_i,
    output axi_fields_pkg::b_word_t      b_word_async_o,

    // AXI master, write address
    output logic                         m_aw_valid_o,
    input  logic                         m_aw_ready_i,
    output axi_fields_pkg::addr_t        m_aw_addr_o,
    output axi_fields_pkg::id_t          m_aw_id_o,
    output axi_fields_pkg::len_t         m_aw_len_o,
    output axi_fields_pkg::size_t        m_aw_size_o,
    output axi_fields_pkg::burst_t       m_aw_burst_o,
    output logic                         m_aw_lock_o,
    output axi_fields_pkg::cache_t       m_aw_cache_o,
    output axi_fields_pkg::prot_t        m_aw_prot_o,

    // AXI master, write data
    output logic                         m_w_valid_o,
    input  logic                         m_w_ready_i,
    output axi_fields_pkg::data_t        m_w_data_o,
    output axi_fields_pkg::strb_t        m_w_strb_o,
    output logic                         m_w_last_o,

    // AXI master, write response
    input  logic                         m_b_valid_i,
    output logic                         m_b_ready_o,
    input  axi_fields_pkg::resp_t        m_b_resp_i,
    input  axi_fields_pkg::id_t          m_b_id_i
);

    axi_fields_pkg::aw_word_t aw_ring_word;
    axi_fields_pkg::aw_word_t aw_buf_word;
    logic                     aw_ring_valid;
    logic                     aw_ring_ready;

    axi_fields_pkg::w_word_t  w_ring_word;
    axi_fields_pkg::w_word_t  w_buf_word;
    logic                     w_ring_valid;
    logic                     w_ring_ready;

    axi_fields_pkg::b_word_t  b_word;

    // Write address channel
    dc_ring_reader #(
        .WORD_WIDTH(axi_fields_pkg::AW_WORD_WIDTH)
    ) aw_ring (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wr_ptr_async_i(aw_wr_ptr_i),
        .rd_ptr_o      (aw_rd_ptr_o),
        .word_async_i  (aw_word_async_i),
        .word_o        (aw_ring_word),
        .valid_o       (aw_ring_valid),
        .ready_i       (aw_ring_ready)
    );

    channel_buffer #(
        .WORD_WIDTH(axi_fields_pkg::AW_WORD_WIDTH)
    ) aw_buffer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_word_i  (aw_ring_word),
        .in_valid_i (aw_ring_valid),
        .in_ready_o (aw_ring_ready),
        .out_word_o (aw_buf_word),
        .out_valid_o(m_aw_valid_o),
        .out_ready_i(m_aw_ready_i)
    );

    assign m_aw_cache_o =
        aw_buf_word[axi_fields_pkg::AW_CACHE_LSB +: axi_fields_pkg::CACHE_WIDTH];
    assign m_aw_prot_o  =
        aw_buf_word[axi_fields_pkg::AW_PROT_LSB +: axi_fields_pkg::PROT_WIDTH];
    assign m_aw_lock_o  = aw_buf_word[axi_fields_pkg::AW_LOCK_LSB];
    assign m_aw_burst_o =
        aw_buf_word[axi_fields_pkg::AW_BURST_LSB +: axi_fields_pkg::BURST_WIDTH];
    assign m_aw_size_o  =
        aw_buf_word[axi_fields_pkg::AW_SIZE_LSB +: axi_fields_pkg::SIZE_WIDTH];
    assign m_aw_len_o   =
        aw_buf_word[axi_fields_pkg::AW_LEN_LSB +: axi_fields_pkg::LEN_WIDTH];
    assign m_aw_addr_o  =
        aw_buf_word[axi_fields_pkg::AW_ADDR_LSB +: axi_fields_pkg::ADDR_WIDTH];
    assign m_aw_id_o    =
        aw_buf_word[axi_fields_pkg::AW_ID_LSB +: axi_fields_pkg::ID_WIDTH];

    // Write data channel
    dc_ring_reader #(
        .WORD_WIDTH(axi_fields_pkg::W_WORD_WIDTH)
    ) w_ring (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wr_ptr_async_i(w_wr_ptr_i),
        .rd_ptr_o      (w_rd_ptr_o),
        .word_async_i  (w_word_async_i),
        .word_o        (w_ring_word),
        .valid_o       (w_ring_valid),
        .ready_i       (w_ring_ready)
    );

    channel_buffer #(
        .WORD_WIDTH(axi_fields_pkg::W_WORD_WIDTH)
    ) w_buffer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_word_i  (w_ring_word),
        .in_valid_i (w_ring_valid),
        .in_ready_o (w_ring_ready),
        .out_word_o (w_buf_word),
        .out_valid_o(m_w_valid_o),
        .out_ready_i(m_w_ready_i)
    );

    assign m_w_last_o = w_buf_word[axi_fields_pkg::W_LAST_LSB];
    assign m_w_data_o =
        w_buf_word[axi_fields_pkg::W_DATA_LSB +: axi_fields_pkg::DATA_WIDTH];
    assign m_w_strb_o =
        w_buf_word[axi_fields_pkg::W_STRB_LSB +: axi_fields_pkg::STRB_WIDTH];

    // Write response back to the remote half
    assign b_word[axi_fields_pkg::B_RESP_LSB +: axi_fields_pkg::RESP_WIDTH] = m_b_resp_i;
    assign b_word[axi_fields_pkg::B_ID_LSB +: axi_fields_pkg::ID_WIDTH]     = m_b_id_i;

    dc_ring_writer #(
        .WORD_WIDTH(axi_fields_pkg::B_WORD_WIDTH)
    ) b_ring (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .word_i        (b_word),
        .valid_i       (m_b_valid_i),
        .ready_o       (m_b_ready_o),
        .wr_ptr_o      (b_wr_ptr_o),
        .rd_ptr_async_i(b_rd_ptr_i),
        .word_async_o  (b_word_async_o)
    );

endmodule

/* rtl/channel_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Two-entry FIFO; out_valid_o and out_word_o come straight from registers.
// A word accepted on an edge is presented from the next cycle.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module channel_buffer #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic [WORD_WIDTH-1:0] in_word_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,

    output logic [WORD_WIDTH-1:0] out_word_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i
);

    logic [WORD_WIDTH-1:0] entry_q [2];
    logic                  wr_idx_q;
    logic                  rd_idx_q;
    logic [1:0]            count_q;
    logic                  push;
    logic                  pop;

    assign in_ready_o  = (count_q != 2'd2);
    assign out_valid_o = (count_q != 2'd0);
    assign out_word_o  = entry_q[rd_idx_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_idx_q <= 1'b0;
            rd_idx_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_idx_q <= !wr_idx_q;
            end
            if (pop) begin
                rd_idx_q <= !rd_idx_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[wr_idx_q] <= in_word_i;
        end
    end

endmodule

/* rtl/dc_ring_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Clock-crossing ring constants and Gray pointer helpers.
// RING_DEPTH must be a power of two; pointers carry one wrap bit.
// ~~~~~~~~~~~~~~~~~~~~
package dc_ring_pkg;

    localparam int unsigned RING_DEPTH  = 8;
    localparam int unsigned IDX_WIDTH   = $clog2(RING_DEPTH);
    localparam int unsigned PTR_WIDTH   = IDX_WIDTH + 1;
    localparam int unsigned SYNC_STAGES = 2;

    typedef logic [PTR_WIDTH-1:0] ring_ptr_t;
    typedef logic [PTR_WIDTH-1:0] ring_bin_t;
    typedef logic [IDX_WIDTH-1:0] ring_idx_t;

    function automatic ring_bin_t gray_to_bin(input ring_ptr_t gray);
        ring_bin_t bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Entry index named by a Gray pointer
    function automatic ring_idx_t ring_index(input ring_ptr_t gray);
        ring_bin_t bin;
        bin = gray_to_bin(gray);
        return bin[IDX_WIDTH-1:0];
    endfunction

    // One Gray step forward
    function automatic ring_ptr_t ring_next(input ring_ptr_t gray);
        ring_bin_t bin;
        bin = gray_to_bin(gray) + ring_bin_t'(1);
        return bin ^ (bin >> 1);
    endfunction

endpackage

/* rtl/dc_ring_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Consumer side of a clock-crossing ring. The remote half must hold the
// entry at our read index stable until our read pointer moves past it.
// word_o is combinational from word_async_i.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dc_ring_reader #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  dc_ring_pkg::ring_ptr_t wr_ptr_async_i,
    output dc_ring_pkg::ring_ptr_t rd_ptr_o,
    input  logic [WORD_WIDTH-1:0] word_async_i,

    output logic [WORD_WIDTH-1:0] word_o,
    output logic                  valid_o,
    input  logic                  ready_i
);

    dc_ring_pkg::ring_ptr_t wr_sync_q [dc_ring_pkg::SYNC_STAGES];
    dc_ring_pkg::ring_ptr_t wr_ptr_sync;
    dc_ring_pkg::ring_ptr_t rd_ptr_q;
    logic                   pop;

    // Remote write pointer into our clock domain
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < dc_ring_pkg::SYNC_STAGES; i++) begin
                wr_sync_q[i] <= '0;
            end
        end else begin
            wr_sync_q[0] <= wr_ptr_async_i;
            for (int i = 1; i < dc_ring_pkg::SYNC_STAGES; i++) begin
                wr_sync_q[i] <= wr_sync_q[i-1];
            end
        end
    end

    assign wr_ptr_sync = wr_sync_q[dc_ring_pkg::SYNC_STAGES-1];

    // Not empty while the pointers differ
    assign valid_o = (wr_ptr_sync != rd_ptr_q);
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (pop) begin
            rd_ptr_q <= dc_ring_pkg::ring_next(rd_ptr_q);
        end
    end

    assign rd_ptr_o = rd_ptr_q;

    // Remote entry at our index is settled once the write pointer is seen
    assign word_o = word_async_i;

endmodule

/* rtl/dc_ring_writer.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Producer side of a clock-crossing ring with local entry storage.
// word_async_o is read with the unsynchronized remote read pointer; the
// remote half samples it only after our write pointer has reached it.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dc_ring_writer #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic [WORD_WIDTH-1:0] word_i,
    input  logic                  valid_i,
    output logic                  ready_o,

    output dc_ring_pkg::ring_ptr_t wr_ptr_o,
    input  dc_ring_pkg::ring_ptr_t rd_ptr_async_i,
    output logic [WORD_WIDTH-1:0] word_async_o
);

    localparam int unsigned PW = dc_ring_pkg::PTR_WIDTH;

    logic [WORD_WIDTH-1:0]  entry_q [dc_ring_pkg::RING_DEPTH];
    dc_ring_pkg::ring_ptr_t rd_sync_q [dc_ring_pkg::SYNC_STAGES];
    dc_ring_pkg::ring_ptr_t rd_ptr_sync;
    dc_ring_pkg::ring_ptr_t wr_ptr_q;
    logic                   full;
    logic                   push;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < dc_ring_pkg::SYNC_STAGES; i++) begin
                rd_sync_q[i] <= '0;
            end
        end else begin
            rd_sync_q[0] <= rd_ptr_async_i;
            for (int i = 1; i < dc_ring_pkg::SYNC_STAGES; i++) begin
                rd_sync_q[i] <= rd_sync_q[i-1];
            end
        end
    end

    assign rd_ptr_sync = rd_sync_q[dc_ring_pkg::SYNC_STAGES-1];

    // Gray full test: top two bits inverted, the rest equal
    assign full = (wr_ptr_q[PW-1:PW-2] == ~rd_ptr_sync[PW-1:PW-2])
               && (wr_ptr_q[PW-3:0] == rd_ptr_sync[PW-3:0]);

    assign ready_o = !full;
    assign push    = valid_i && !full;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (push) begin
            wr_ptr_q <= dc_ring_pkg::ring_next(wr_ptr_q);
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[dc_ring_pkg::ring_index(wr_ptr_q)] <= word_i;
        end
    end

    assign wr_ptr_o     = wr_ptr_q;
    assign word_async_o = entry_q[dc_ring_pkg::ring_index(rd_ptr_async_i)];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f project.f \
    --top-module tb_axi_slice_dc_master \
    --Mdir "$BUILD_DIR" -o sim_axi_slice_dc_master
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_axi_slice_dc_master" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* verification/tb_axi_slice_dc_master.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the master half, write path only. Both halves share one
// clock, so the remote model reads the DUT pointers without synchronizers.
// Stops at the first mismatch.
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_axi_slice_dc_master;

    localparam int N_AW  = 16;
    localparam int N_W   = 16;
    localparam int N_B   = 16;
    localparam int DEPTH = dc_ring_pkg::RING_DEPTH;
    localparam int PW    = dc_ring_pkg::PTR_WIDTH;
    localparam int LIMIT = 4 * (N_AW + N_W + N_B) * (dc_ring_pkg::SYNC_STAGES + 4);

    typedef logic [PW-1:0] bin_t;
    localparam bin_t FULL_GAP = bin_t'(DEPTH);

    // AW fields as compared at the master port
    typedef struct packed {
        axi_fields_pkg::id_t    id;
        axi_fields_pkg::addr_t  addr;
        axi_fields_pkg::len_t   len;
        axi_fields_pkg::size_t  size;
        axi_fields_pkg::burst_t burst;
        logic                   lock;
        axi_fields_pkg::cache_t cache;
        axi_fields_pkg::prot_t  prot;
    } aw_fields_t;

    typedef struct packed {
        axi_fields_pkg::strb_t strb;
        axi_fields_pkg::data_t data;
        logic                  last;
    } w_fields_t;

    logic                     clk_i;
    logic                     rst_n_i;
    dc_ring_pkg::ring_ptr_t   aw_wr_ptr_i;
    dc_ring_pkg::ring_ptr_t   aw_rd_ptr_o;
    axi_fields_pkg::aw_word_t aw_word_async_i;
    dc_ring_pkg::ring_ptr_t   w_wr_ptr_i;
    dc_ring_pkg::ring_ptr_t   w_rd_ptr_o;
    axi_fields_pkg::w_word_t  w_word_async_i;
    dc_ring_pkg::ring_ptr_t   b_wr_ptr_o;
    dc_ring_pkg::ring_ptr_t   b_rd_ptr_i;
    axi_fields_pkg::b_word_t  b_word_async_o;
    logic                     m_aw_valid_o;
    logic                     m_aw_ready_i;
    axi_fields_pkg::addr_t    m_aw_addr_o;
    axi_fields_pkg::id_t      m_aw_id_o;
    axi_fields_pkg::len_t     m_aw_len_o;
    axi_fields_pkg::size_t    m_aw_size_o;
    axi_fields_pkg::burst_t   m_aw_burst_o;
    logic                     m_aw_lock_o;
    axi_fields_pkg::cache_t   m_aw_cache_o;
    axi_fields_pkg::prot_t    m_aw_prot_o;
    logic                     m_w_valid_o;
    logic                     m_w_ready_i;
    axi_fields_pkg::data_t    m_w_data_o;
    axi_fields_pkg::strb_t    m_w_strb_o;
    logic                     m_w_last_o;
    logic                     m_b_valid_i;
    logic                     m_b_ready_o;
    axi_fields_pkg::resp_t    m_b_resp_i;
    axi_fields_pkg::id_t      m_b_id_i;

    // Remote half storage and state
    axi_fields_pkg::aw_word_t aw_mem [DEPTH];
    axi_fields_pkg::w_word_t  w_mem [DEPTH];
    bin_t                     aw_wr_bin = '0;
    bin_t                     w_wr_bin = '0;
    bin_t                     b_rd_bin = '0;

    axi_fields_pkg::aw_word_t aw_exp [$];
    axi_fields_pkg::w_word_t  w_exp [$];
    axi_fields_pkg::b_word_t  b_exp [$];

    integer     seed = 48585;
    int         cycles = 0;
    int         aw_sent = 0;
    int         w_sent = 0;
    int         aw_seen = 0;
    int         w_seen = 0;
    int         b_issued = 0;
    int         b_accepted = 0;
    int         b_read = 0;
    int         aw_stretch = 0;
    int         w_stretch = 0;
    logic       run = 1'b0;
    logic       b_stall_phase = 1'b1;
    logic       b_read_en = 1'b0;
    logic       b_fire_q = 1'b0;
    logic       aw_hold = 1'b0;
    logic       w_hold = 1'b0;
    aw_fields_t aw_held;
    w_fields_t  w_held;
    aw_fields_t aw_obs;
    w_fields_t  w_obs;

    axi_slice_dc_master UUT (.*);

    always #20 clk_i = ~clk_i;

    function automatic bin_t to_gray(input bin_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic bin_t from_gray(input bin_t gray);
        bin_t bin;
        bin = gray;
        for (int s = 1; s < PW; s++) begin
            bin = bin ^ (gray >> s);
        end
        return bin;
    endfunction

    function automatic logic [PW-2:0] index_of(input bin_t gray);
        bin_t bin;
        bin = from_gray(gray);
        return bin[PW-2:0];
    endfunction

    // Expected fields of a packed AW word
    function automatic aw_fields_t expected_aw(input axi_fields_pkg::aw_word_t word);
        aw_fields_t f;
        f.cache = word[3:0];
        f.prot  = word[6:4];
        f.lock  = word[7];
        f.burst = word[9:8];
        f.size  = word[12:10];
        f.len   = word[20:13];
        f.addr  = word[52:21];
        f.id    = word[56:53];
        return f;
    endfunction

    function automatic w_fields_t expected_w(input axi_fields_pkg::w_word_t word);
        w_fields_t f;
        f.last = word[0];
        f.data = word[32:1];
        f.strb = word[36:33];
        return f;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "first mismatch reached");
        end
    endtask

    assign aw_word_async_i = aw_mem[index_of(aw_rd_ptr_o)];
    assign w_word_async_i  = w_mem[index_of(w_rd_ptr_o)];
    assign aw_obs = {m_aw_id_o, m_aw_addr_o, m_aw_len_o, m_aw_size_o, m_aw_burst_o,
                     m_aw_lock_o, m_aw_cache_o, m_aw_prot_o};
    assign w_obs  = {m_w_strb_o, m_w_data_o, m_w_last_o};

    // Remote half and AXI slave, driven on the falling edge
    always @(negedge clk_i) begin
        logic [31:0] r;
        if (run) begin
            r = $random(seed);
            if (aw_stretch == 0) begin
                m_aw_ready_i = r[0];
                aw_stretch = int'(r[4:1]);
            end else begin
                aw_stretch = aw_stretch - 1;
            end
            if (w_stretch == 0) begin
                m_w_ready_i = r[5];
                w_stretch = int'(r[9:6]);
            end else begin
                w_stretch = w_stretch - 1;
            end
            if (aw_sent < N_AW && r[10] && (aw_wr_bin - from_gray(aw_rd_ptr_o)) != FULL_GAP) begin
                aw_mem[aw_wr_bin[PW-2:0]] = axi_fields_pkg::aw_word_t'({$random(seed),
                                                                       $random(seed)});
                aw_exp.push_back(aw_mem[aw_wr_bin[PW-2:0]]);
                aw_wr_bin = aw_wr_bin + bin_t'(1);
                aw_wr_ptr_i = to_gray(aw_wr_bin);
                aw_sent++;
            end
            if (w_sent < N_W && r[11] && (w_wr_bin - from_gray(w_rd_ptr_o)) != FULL_GAP) begin
                w_mem[w_wr_bin[PW-2:0]] = axi_fields_pkg::w_word_t'({$random(seed),
                                                                    $random(seed)});
                w_exp.push_back(w_mem[w_wr_bin[PW-2:0]]);
                w_wr_bin = w_wr_bin + bin_t'(1);
                w_wr_ptr_i = to_gray(w_wr_bin);
                w_sent++;
            end
            // New response only once the previous one was taken
            if (!m_b_valid_i || b_fire_q) begin
                m_b_valid_i = (b_issued < N_B) && r[12];
                m_b_resp_i = r[14:13];
                m_b_id_i = r[18:15];
                if (m_b_valid_i) begin
                    b_issued++;
                end
            end
            if (b_read_en && r[19] && b_rd_bin != from_gray(b_wr_ptr_o)) begin
                check_value(64'(b_word_async_o), 64'(b_exp.pop_front()), "B word at remote");
                b_rd_bin = b_rd_bin + bin_t'(1);
                b_rd_ptr_i = to_gray(b_rd_bin);
                b_read++;
            end
        end
    end

    // Compare process
    always @(posedge clk_i) begin
        b_fire_q <= m_b_valid_i && m_b_ready_o;
        if (run) begin
            if (b_stall_phase) begin
                check_value(64'(m_b_ready_o), 64'(b_accepted < DEPTH), "B ready vs accepted");
            end
            if (m_b_valid_i && m_b_ready_o) begin
                b_exp.push_back({m_b_id_i, m_b_resp_i});
                b_accepted++;
            end
            if (aw_hold) begin
                check_value(64'({m_aw_valid_o, aw_obs}), 64'({1'b1, aw_held}), "AW held");
            end
            if (w_hold) begin
                check_value(64'({m_w_valid_o, w_obs}), 64'({1'b1, w_held}), "W held");
            end
            if (m_aw_valid_o && m_aw_ready_i) begin
                check_value(64'(aw_exp.size() != 0), 64'(1), "AW transfer with no word sent");
                check_value(64'(aw_obs), 64'(expected_aw(aw_exp.pop_front())), "AW fields");
                aw_seen++;
            end
            if (m_w_valid_o && m_w_ready_i) begin
                check_value(64'(w_exp.size() != 0), 64'(1), "W beat with no word sent");
                check_value(64'(w_obs), 64'(expected_w(w_exp.pop_front())), "W fields");
                w_seen++;
            end
            aw_hold <= m_aw_valid_o && !m_aw_ready_i;
            aw_held <= aw_obs;
            w_hold  <= m_w_valid_o && !m_w_ready_i;
            w_held  <= w_obs;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles: %0d AW, %0d W, %0d B done", cycles,
                     aw_seen, w_seen, b_read);
            $display("tests failed");
            $fatal(1, "run did not finish in time");
        end
    end

    initial begin
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        aw_wr_ptr_i = '0;
        w_wr_ptr_i = '0;
        b_rd_ptr_i = '0;
        m_aw_ready_i = 1'b0;
        m_w_ready_i = 1'b0;
        m_b_valid_i = 1'b0;
        m_b_resp_i = '0;
        m_b_id_i = '0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        check_value(64'({m_aw_valid_o, m_w_valid_o, m_b_ready_o}), 64'(3'b001),
                    "valid and ready after reset");
        check_value(64'({aw_rd_ptr_o, w_rd_ptr_o, b_wr_ptr_o}), 64'(0), "pointers after reset");
        run = 1'b1;

        // B ring fills while the remote half does not read
        wait (b_accepted == DEPTH);
        repeat (6) @(negedge clk_i);
        b_stall_phase = 1'b0;
        b_read_en = 1'b1;
        wait (m_b_ready_o);
        check_value(64'(b_read > 0), 64'(1), "B ready rose before any remote read");

        wait (aw_seen == N_AW && w_seen == N_W && b_read == N_B);
        repeat (3 * dc_ring_pkg::SYNC_STAGES + 4) @(negedge clk_i);
        if (aw_exp.size() == 0 && w_exp.size() == 0 && b_exp.size() == 0
            && !m_aw_valid_o && !m_w_valid_o) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Words left over or extra valid after the last transfer");
            $display("tests failed");
            $fatal(1, "run ended with leftover words");
        end
    end

endmodule
